// File: verilog.f
+incdir+include
verilog/mips_pkg.sv
verilog/mips_control.sv
verilog/mips_register_file.sv
verilog/mips_decode_stage.sv
verilog/mips_execute_stage.sv
verilog/mips_result_stage.sv
verilog/mips_datapath_top.sv
dv/mips_datapath_tb.sv

// File: Makefile
# Verilator flow for the MIPS datapath testbench
VERILATOR ?= verilator
TOP       ?= mips_datapath_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The log decides the result, so the simulator status is not used here
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/mips_datapath_tb.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_datapath_tb;

    localparam logic [5:0] BAD_OPS [8] = '{6'h02, 6'h03, 6'h05, 6'h0a,
                                           6'h0f, 6'h20, 6'h28, 6'h3f};
    localparam logic [5:0] BAD_FUNCTS [8] = '{6'h02, 6'h03, 6'h08, 6'h21,
                                              6'h23, 6'h26, 6'h27, 6'h2b};

    logic                           i_clk;
    logic                           i_rst;
    logic                           i_instr_valid;
    mips_pkg::instr_t               i_instr;
    logic                           o_wb_en;
    logic [`MIPS_NB_REG_ADDR-1:0]   o_wb_addr;
    logic [`MIPS_NB_DATA-1:0]       o_wb_data;
    logic                           o_store_en;
    logic [`MIPS_NB_DMEM_ADDR-1:0]  o_store_addr;
    logic [`MIPS_NB_DATA-1:0]       o_store_data;
    logic                           o_branch_taken;
    logic                           o_illegal;

    // Reference model state and its predictions
    logic [`MIPS_NB_DATA-1:0]       model_regs [1 << `MIPS_NB_REG_ADDR];
    logic [`MIPS_NB_DATA-1:0]       model_mem [`MIPS_DMEM_DEPTH];
    logic                           exp_wb_en;
    logic [`MIPS_NB_REG_ADDR-1:0]   exp_wb_addr;
    logic [`MIPS_NB_DATA-1:0]       exp_wb_data;
    logic                           exp_store_en;
    logic [`MIPS_NB_DMEM_ADDR-1:0]  exp_store_addr;
    logic [`MIPS_NB_DATA-1:0]       exp_store_data;
    logic                           exp_branch;
    logic                           exp_illegal;
    logic [31:0]                    rng_state;
    int                             checks;
    int                             errors;

    mips_datapath_top i_mips_datapath_top (.*);

    always #10 i_clk = ~i_clk;

    // Watchdog for the whole run
    initial begin
        #1000000;
        $display("Timeout: the run did not finish within the watchdog limit");
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic wait_clk(input logic level);
        int guard;
        guard = 0;
        while ((i_clk !== level) && (guard < 4)) begin
            guard++;
            @(i_clk);
        end
        if (i_clk !== level) begin
            $display("Timeout: clock never reached level %0b", level);
            $display("SIMULATION FAILED");
            $finish;
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic mips_pkg::instr_t make_r(input logic [5:0] funct, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd,
                                                input logic [4:0] shamt);
        mips_pkg::instr_t w;
        w.r = '{mips_pkg::OP_RTYPE, rs, rt, rd, shamt, funct};
        return w;
    endfunction

    function automatic mips_pkg::instr_t make_i(input logic [5:0] opcode, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        mips_pkg::instr_t w;
        w.i = '{opcode, rs, rt, imm};
        return w;
    endfunction

    // Arithmetic and logic mix over registers 0 to 7
    function automatic mips_pkg::instr_t gen_alu();
        logic [31:0] r;
        logic [31:0] q;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        r = rand32();
        q = rand32();
        rs = {2'b0, r[2:0]};
        rt = {2'b0, r[5:3]};
        rd = {2'b0, r[8:6]};
        case (int'(r[31:24]) % 9)
            0: return make_r(mips_pkg::FN_ADD, rs, rt, rd, 5'd0);
            1: return make_r(mips_pkg::FN_SUB, rs, rt, rd, 5'd0);
            2: return make_r(mips_pkg::FN_AND, rs, rt, rd, 5'd0);
            3: return make_r(mips_pkg::FN_OR, rs, rt, rd, 5'd0);
            4: return make_r(mips_pkg::FN_SLT, rs, rt, rd, 5'd0);
            5: return make_r(mips_pkg::FN_SLL, rs, rt, rd, q[20:16]);
            6: return make_i(mips_pkg::OP_ADDI, rs, rt, q[15:0]);
            7: return make_i(mips_pkg::OP_ANDI, rs, rt, q[15:0]);
            default: return make_i(mips_pkg::OP_ORI, rs, rt, q[15:0]);
        endcase
    endfunction

    task automatic predict(input mips_pkg::instr_t instr, input logic valid);
        logic [`MIPS_NB_DATA-1:0] rs_val;
        logic [`MIPS_NB_DATA-1:0] rt_val;
        logic [`MIPS_NB_DATA-1:0] imm;
        logic [`MIPS_NB_DATA-1:0] addr;
        rs_val = model_regs[instr.i.rs];
        rt_val = model_regs[instr.i.rt];
        imm = {{(`MIPS_NB_DATA-16){instr.i.imm[15]}}, instr.i.imm};
        addr = rs_val + imm;
        exp_wb_en = 1'b0;
        exp_wb_addr = instr.i.rt;
        exp_wb_data = '0;
        exp_store_en = 1'b0;
        exp_store_addr = addr[`MIPS_NB_DMEM_ADDR+1:2];
        exp_store_data = rt_val;
        exp_branch = 1'b0;
        exp_illegal = 1'b0;
        case (instr.i.opcode)
            mips_pkg::OP_RTYPE: begin
                exp_wb_en = 1'b1;
                exp_wb_addr = instr.r.rd;
                case (instr.r.funct)
                    mips_pkg::FN_ADD: exp_wb_data = rs_val + rt_val;
                    mips_pkg::FN_SUB: exp_wb_data = rs_val - rt_val;
                    mips_pkg::FN_AND: exp_wb_data = rs_val & rt_val;
                    mips_pkg::FN_OR:  exp_wb_data = rs_val | rt_val;
                    mips_pkg::FN_SLT: begin
                        exp_wb_data = ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
                    end
                    mips_pkg::FN_SLL: exp_wb_data = rt_val << instr.r.shamt;
                    default: begin
                        exp_wb_en = 1'b0;
                        exp_illegal = 1'b1;
                    end
                endcase
            end
            mips_pkg::OP_ADDI: exp_wb_data = rs_val + imm;
            mips_pkg::OP_ANDI: exp_wb_data = rs_val & imm;
            mips_pkg::OP_ORI:  exp_wb_data = rs_val | imm;
            mips_pkg::OP_LW:   exp_wb_data = model_mem[exp_store_addr];
            mips_pkg::OP_SW:   exp_store_en = 1'b1;
            mips_pkg::OP_BEQ:  exp_branch = (rs_val == rt_val);
            default:           exp_illegal = 1'b1;
        endcase
        // I-type writers share one destination rule
        if (instr.i.opcode inside {mips_pkg::OP_ADDI, mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
                                   mips_pkg::OP_LW}) begin
            exp_wb_en = 1'b1;
        end
        if (!valid) begin
            exp_wb_en = 1'b0;
            exp_store_en = 1'b0;
            exp_branch = 1'b0;
            exp_illegal = 1'b0;
        end
    endtask

    task automatic check_writeback(input mips_pkg::instr_t instr, input logic en,
                                   input logic [`MIPS_NB_REG_ADDR-1:0] addr,
                                   input logic [`MIPS_NB_DATA-1:0] data);
        checks++;
        if ((o_wb_en !== en) || (en && ((o_wb_addr !== addr) || (o_wb_data !== data)))) begin
            errors++;
            $display("MISMATCH t=%0t wb %08h got %0b r%0d=%08h want %0b r%0d=%08h",
                     $time, instr, o_wb_en, o_wb_addr, o_wb_data, en, addr, data);
        end
    endtask

    task automatic check_store(input mips_pkg::instr_t instr, input logic en,
                               input logic [`MIPS_NB_DMEM_ADDR-1:0] addr,
                               input logic [`MIPS_NB_DATA-1:0] data);
        checks++;
        if ((o_store_en !== en) ||
            (en && ((o_store_addr !== addr) || (o_store_data !== data)))) begin
            errors++;
            $display("MISMATCH t=%0t store %08h got %0b [%0d]=%08h want %0b [%0d]=%08h",
                     $time, instr, o_store_en, o_store_addr, o_store_data, en, addr, data);
        end
    endtask

    task automatic check_branch(input mips_pkg::instr_t instr, input logic taken);
        checks++;
        if (o_branch_taken !== taken) begin
            errors++;
            $display("MISMATCH t=%0t branch instr=%08h got %0b want %0b",
                     $time, instr, o_branch_taken, taken);
        end
    endtask

    task automatic check_illegal(input mips_pkg::instr_t instr, input logic illegal);
        checks++;
        if (o_illegal !== illegal) begin
            errors++;
            $display("MISMATCH t=%0t illegal instr=%08h got %0b want %0b",
                     $time, instr, o_illegal, illegal);
        end
    endtask

    // Drive at the rising edge, check at the falling edge, then retire in the model
    task automatic step(input mips_pkg::instr_t instr, input logic valid);
        wait_clk(1'b1);
        i_instr <= instr;
        i_instr_valid <= valid;
        wait_clk(1'b0);
        predict(instr, valid);
        check_writeback(instr, exp_wb_en, exp_wb_addr, exp_wb_data);
        check_store(instr, exp_store_en, exp_store_addr, exp_store_data);
        check_branch(instr, exp_branch);
        check_illegal(instr, exp_illegal);
        if (exp_wb_en && (exp_wb_addr != '0)) begin
            model_regs[exp_wb_addr] = exp_wb_data;
        end
        if (exp_store_en) begin
            model_mem[exp_store_addr] = exp_store_data;
        end
    endtask

    task automatic apply_reset();
        wait_clk(1'b1);
        i_rst <= 1'b1;
        i_instr_valid <= 1'b0;
        for (int cyc = 0; cyc < 4; cyc++) begin
            wait_clk(1'b0);
            check_writeback(i_instr, 1'b0, '0, '0);
            check_store(i_instr, 1'b0, '0, '0);
            check_branch(i_instr, 1'b0);
            check_illegal(i_instr, 1'b0);
            wait_clk(1'b1);
        end
        i_rst <= 1'b0;
        wait_clk(1'b0);
        for (int idx = 0; idx < (1 << `MIPS_NB_REG_ADDR); idx++) begin
            model_regs[idx] = '0;
        end
        for (int idx = 0; idx < `MIPS_DMEM_DEPTH; idx++) begin
            model_mem[idx] = '0;
        end
    endtask

    // or rk, rk, r0 shows each low register at o_wb_data
    task automatic read_back_regs();
        for (logic [4:0] k = 5'd0; k < 5'd8; k++) begin
            step(make_r(mips_pkg::FN_OR, k, 5'd0, k, 5'd0), 1'b1);
        end
    endtask

    task automatic finish_test(input string name, input int c0, input int e0);
        $display("Test %s done: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    initial begin
        int               c0;
        int               e0;
        logic [31:0]      r;
        logic [4:0]       src;
        logic [4:0]       rs;
        logic [15:0]      offset;
        mips_pkg::instr_t w;
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_instr_valid = 1'b0;
        i_instr = '0;
        rng_state = 32'h1e61ead3;
        checks = 0;
        errors = 0;

        c0 = checks;
        e0 = errors;
        apply_reset();
        finish_test("startup_reset", c0, e0);

        c0 = checks;
        e0 = errors;
        repeat (300) step(gen_alu(), 1'b1);
        finish_test("alu_writeback", c0, e0);

        c0 = checks;
        e0 = errors;
        repeat (8) begin
            r = rand32();
            step(make_i(mips_pkg::OP_ADDI, {2'b0, r[2:0]}, 5'd0, r[31:16]), 1'b1);
            step(make_r(mips_pkg::FN_ADD, 5'd0, 5'd0, {2'b0, r[5:3]}, 5'd0), 1'b1);
        end
        finish_test("register_zero", c0, e0);

        c0 = checks;
        e0 = errors;
        repeat (20) begin
            r = rand32();
            src = (r[2:0] == 3'd0) ? 5'd1 : {2'b0, r[2:0]};
            offset = {8'b0, r[13:8], 2'b00};
            step(make_i(mips_pkg::OP_ADDI, 5'd0, src, r[31:16]), 1'b1);
            step(make_i(mips_pkg::OP_SW, 5'd0, src, offset), 1'b1);
            step(make_i(mips_pkg::OP_LW, 5'd0, {2'b0, r[5:3]}, offset), 1'b1);
        end
        finish_test("store_load", c0, e0);

        c0 = checks;
        e0 = errors;
        repeat (40) begin
            r = rand32();
            rs = {2'b0, r[2:0]};
            step(make_i(mips_pkg::OP_BEQ, rs, r[6] ? rs : {2'b0, r[5:3]}, r[31:16]), 1'b1);
        end
        finish_test("branch", c0, e0);

        c0 = checks;
        e0 = errors;
        repeat (30) begin
            r = rand32();
            w = rand32();
            if (r[31]) begin
                w.r.opcode = BAD_OPS[r[2:0]];
            end else begin
                w.r.opcode = mips_pkg::OP_RTYPE;
                w.r.funct = BAD_FUNCTS[r[2:0]];
            end
            step(w, 1'b1);
        end
        read_back_regs();
        finish_test("illegal", c0, e0);

        c0 = checks;
        e0 = errors;
        repeat (40) step(rand32(), 1'b0);
        apply_reset();
        read_back_regs();
        // Every data memory word must read back as zero
        for (int k = 0; k < `MIPS_DMEM_DEPTH; k++) begin
            step(make_i(mips_pkg::OP_LW, 5'd0, 5'(k % 8), 16'(k * 4)), 1'b1);
        end
        finish_test("invalid_and_reset", c0, e0);

        $display("Totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/mips_datapath_top.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_datapath_top (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_instr_valid,
    input  mips_pkg::instr_t                i_instr,
    output logic                            o_wb_en,
    output logic [`MIPS_NB_REG_ADDR-1:0]    o_wb_addr,
    output logic [`MIPS_NB_DATA-1:0]        o_wb_data,
    output logic                            o_store_en,
    output logic [`MIPS_NB_DMEM_ADDR-1:0]   o_store_addr,
    output logic [`MIPS_NB_DATA-1:0]        o_store_data,
    output logic                            o_branch_taken,
    output logic                            o_illegal
);

    logic [`MIPS_NB_DATA-1:0]       read_data_1;
    logic [`MIPS_NB_DATA-1:0]       read_data_2;
    logic [`MIPS_NB_DATA-1:0]       imm_ext;
    logic [`MIPS_NB_REG_ADDR-1:0]   shamt;
    logic                           alu_src;
    logic                           branch;
    logic                           mem_read;
    logic                           mem_write;
    logic                           mem_to_reg;
    mips_pkg::alu_op_t              alu_op;
    logic [`MIPS_NB_DATA-1:0]       alu_result;

    mips_decode_stage u_decode_stage (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .i_write_data   (o_wb_data),
        .o_read_data_1  (read_data_1),
        .o_read_data_2  (read_data_2),
        .o_imm_ext      (imm_ext),
        .o_shamt        (shamt),
        .o_alu_src      (alu_src),
        .o_branch       (branch),
        .o_mem_read     (mem_read),
        .o_mem_write    (mem_write),
        .o_mem_to_reg   (mem_to_reg),
        .o_alu_op       (alu_op),
        .o_wb_en        (o_wb_en),
        .o_wb_addr      (o_wb_addr),
        .o_illegal      (o_illegal)
    );

    mips_execute_stage u_execute_stage (
        .i_read_data_1  (read_data_1),
        .i_read_data_2  (read_data_2),
        .i_imm_ext      (imm_ext),
        .i_shamt        (shamt),
        .i_alu_src      (alu_src),
        .i_alu_op       (alu_op),
        .i_branch       (branch),
        .o_alu_result   (alu_result),
        .o_branch_taken (o_branch_taken)
    );

    // Writeback loops back into decode
    mips_result_stage u_result_stage (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_alu_result   (alu_result),
        .i_store_data   (read_data_2),
        .i_mem_read     (mem_read),
        .i_mem_write    (mem_write),
        .i_mem_to_reg   (mem_to_reg),
        .o_wb_data      (o_wb_data),
        .o_store_en     (o_store_en),
        .o_store_addr   (o_store_addr),
        .o_store_data   (o_store_data)
    );

endmodule

// File: verilog/mips_result_stage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_result_stage (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic [`MIPS_NB_DATA-1:0]        i_alu_result,
    input  logic [`MIPS_NB_DATA-1:0]        i_store_data,
    input  logic                            i_mem_read,
    input  logic                            i_mem_write,
    input  logic                            i_mem_to_reg,
    output logic [`MIPS_NB_DATA-1:0]        o_wb_data,
    output logic                            o_store_en,
    output logic [`MIPS_NB_DMEM_ADDR-1:0]   o_store_addr,
    output logic [`MIPS_NB_DATA-1:0]        o_store_data
);

    logic [`MIPS_NB_DATA-1:0]       dmem [`MIPS_DMEM_DEPTH];
    logic [`MIPS_NB_DMEM_ADDR-1:0]  word_addr;
    logic [`MIPS_NB_DATA-1:0]       load_data;

    // Byte address to word index
    assign word_addr = i_alu_result[`MIPS_NB_DMEM_ADDR+1:2];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int idx = 0; idx < `MIPS_DMEM_DEPTH; idx++) begin
                dmem[idx] <= '0;
            end
        end else if (i_mem_write) begin
            dmem[word_addr] <= i_store_data;
        end
    end

    assign load_data = i_mem_read ? dmem[word_addr] : '0;
    assign o_wb_data = i_mem_to_reg ? load_data : i_alu_result;

    assign o_store_en   = i_mem_write;
    assign o_store_addr = word_addr;
    assign o_store_data = i_store_data;

    // Decode must keep stores off while reset is applied
    assert property (@(posedge i_clk) i_rst |-> !i_mem_write);

endmodule

// File: verilog/mips_execute_stage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_execute_stage (
    input  logic [`MIPS_NB_DATA-1:0]        i_read_data_1,
    input  logic [`MIPS_NB_DATA-1:0]        i_read_data_2,
    input  logic [`MIPS_NB_DATA-1:0]        i_imm_ext,
    input  logic [`MIPS_NB_REG_ADDR-1:0]    i_shamt,
    input  logic                            i_alu_src,
    input  mips_pkg::alu_op_t               i_alu_op,
    input  logic                            i_branch,
    output logic [`MIPS_NB_DATA-1:0]        o_alu_result,
    output logic                            o_branch_taken
);

    logic [`MIPS_NB_DATA-1:0] operand_b;
    logic                     less_than;

    assign operand_b = i_alu_src ? i_imm_ext : i_read_data_2;

    // Signed compare for slt
    assign less_than = $signed(i_read_data_1) < $signed(operand_b);

    always_comb begin
        case (i_alu_op)
            mips_pkg::ALU_ADD: begin
                o_alu_result = i_read_data_1 + operand_b;
            end
            mips_pkg::ALU_SUB: begin
                o_alu_result = i_read_data_1 - operand_b;
            end
            mips_pkg::ALU_AND: begin
                o_alu_result = i_read_data_1 & operand_b;
            end
            mips_pkg::ALU_OR: begin
                o_alu_result = i_read_data_1 | operand_b;
            end
            mips_pkg::ALU_SLT: begin
                o_alu_result = {{(`MIPS_NB_DATA-1){1'b0}}, less_than};
            end
            mips_pkg::ALU_SLL: begin
                // Shifts rt, not the selected operand
                o_alu_result = i_read_data_2 << i_shamt;
            end
            default: begin
                o_alu_result = '0;
            end
        endcase
    end

    // beq with a branch level that arrives already qualified
    assign o_branch_taken = i_branch && (i_read_data_1 == i_read_data_2);

endmodule

// File: verilog/mips_decode_stage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_decode_stage (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_instr_valid,
    input  mips_pkg::instr_t                i_instr,
    input  logic [`MIPS_NB_DATA-1:0]        i_write_data,
    output logic [`MIPS_NB_DATA-1:0]        o_read_data_1,
    output logic [`MIPS_NB_DATA-1:0]        o_read_data_2,
    output logic [`MIPS_NB_DATA-1:0]        o_imm_ext,
    output logic [`MIPS_NB_REG_ADDR-1:0]    o_shamt,
    output logic                            o_alu_src,
    output logic                            o_branch,
    output logic                            o_mem_read,
    output logic                            o_mem_write,
    output logic                            o_mem_to_reg,
    output mips_pkg::alu_op_t               o_alu_op,
    output logic                            o_wb_en,
    output logic [`MIPS_NB_REG_ADDR-1:0]    o_wb_addr,
    output logic                            o_illegal
);

    logic reg_write;
    logic reg_dst;
    logic branch;
    logic mem_read;
    logic mem_write;
    logic illegal;
    logic instr_ok;

    mips_control u_control (
        .i_opcode       (i_instr.r.opcode),
        .i_funct        (i_instr.r.funct),
        .o_reg_write    (reg_write),
        .o_reg_dst      (reg_dst),
        .o_alu_src      (o_alu_src),
        .o_branch       (branch),
        .o_mem_read     (mem_read),
        .o_mem_write    (mem_write),
        .o_mem_to_reg   (o_mem_to_reg),
        .o_illegal      (illegal),
        .o_alu_op       (o_alu_op)
    );

    // Only a valid, legal instruction may change state
    assign instr_ok    = i_instr_valid && !illegal;
    assign o_wb_en     = reg_write && instr_ok;
    assign o_mem_write = mem_write && instr_ok;
    assign o_mem_read  = mem_read && instr_ok;
    assign o_branch    = branch && instr_ok;
    assign o_illegal   = illegal && i_instr_valid;

    // rd for R-type, rt for I-type
    assign o_wb_addr = reg_dst ? i_instr.r.rd : i_instr.i.rt;
    assign o_shamt   = i_instr.r.shamt;

    // Sign extension applies to andi and ori as well
    assign o_imm_ext = {{(`MIPS_NB_DATA-16){i_instr.i.imm[15]}}, i_instr.i.imm};

    mips_register_file u_register_file (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_write_en     (o_wb_en),
        .i_read_addr_1  (i_instr.r.rs),
        .i_read_addr_2  (i_instr.r.rt),
        .i_write_addr   (o_wb_addr),
        .i_write_data   (i_write_data),
        .o_read_data_1  (o_read_data_1),
        .o_read_data_2  (o_read_data_2)
    );

endmodule

// File: verilog/mips_register_file.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_register_file (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_write_en,
    input  logic [`MIPS_NB_REG_ADDR-1:0]    i_read_addr_1,
    input  logic [`MIPS_NB_REG_ADDR-1:0]    i_read_addr_2,
    input  logic [`MIPS_NB_REG_ADDR-1:0]    i_write_addr,
    input  logic [`MIPS_NB_DATA-1:0]        i_write_data,
    output logic [`MIPS_NB_DATA-1:0]        o_read_data_1,
    output logic [`MIPS_NB_DATA-1:0]        o_read_data_2
);

    localparam int NB_REGS = 1 << `MIPS_NB_REG_ADDR;

    logic [`MIPS_NB_DATA-1:0] regs [NB_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int idx = 0; idx < NB_REGS; idx++) begin
                regs[idx] <= '0;
            end
        end else if (i_write_en && (i_write_addr != '0)) begin
            // Writes to the hardwired index 0 are dropped
            regs[i_write_addr] <= i_write_data;
        end
    end

    // Asynchronous reads
    assign o_read_data_1 = regs[i_read_addr_1];
    assign o_read_data_2 = regs[i_read_addr_2];

    // Register 0 reads zero on both ports once out of reset
    assert property (@(posedge i_clk) disable iff (i_rst)
        ((i_read_addr_1 != '0) || (o_read_data_1 == '0)) &&
        ((i_read_addr_2 != '0) || (o_read_data_2 == '0)));

endmodule

// File: verilog/mips_control.sv
`timescale 1ns/1ps

module mips_control (
    input  logic [5:0]          i_opcode,
    input  logic [5:0]          i_funct,
    output logic                o_reg_write,
    output logic                o_reg_dst,
    output logic                o_alu_src,
    output logic                o_branch,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_mem_to_reg,
    output logic                o_illegal,
    output mips_pkg::alu_op_t   o_alu_op
);

    always_comb begin
        // Defaults describe a no-op
        o_reg_write  = 1'b0;
        o_reg_dst    = 1'b0;
        o_alu_src    = 1'b0;
        o_branch     = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_illegal    = 1'b0;
        o_alu_op     = mips_pkg::ALU_ADD;

        case (i_opcode)
            mips_pkg::OP_RTYPE: begin
                o_reg_write = 1'b1;
                o_reg_dst   = 1'b1;
                case (i_funct)
                    mips_pkg::FN_ADD: o_alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: o_alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: o_alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  o_alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: o_alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL: o_alu_op = mips_pkg::ALU_SLL;
                    default: begin
                        o_reg_write = 1'b0;
                        o_illegal   = 1'b1;
                    end
                endcase
            end
            mips_pkg::OP_ADDI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
            end
            mips_pkg::OP_ANDI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_op    = mips_pkg::ALU_AND;
            end
            mips_pkg::OP_ORI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_op    = mips_pkg::ALU_OR;
            end
            mips_pkg::OP_LW: begin
                o_reg_write  = 1'b1;
                o_alu_src    = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
            end
            mips_pkg::OP_SW: begin
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                // Compare is done in execute; ALU result unused
                o_branch = 1'b1;
                o_alu_op = mips_pkg::ALU_SUB;
            end
            default: begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: verilog/mips_pkg.sv
`include "mips_defines.svh"

package mips_pkg;

    // R-type layout with the most significant field first
    typedef struct packed {
        logic [5:0]                     opcode;
        logic [`MIPS_NB_REG_ADDR-1:0]   rs;
        logic [`MIPS_NB_REG_ADDR-1:0]   rt;
        logic [`MIPS_NB_REG_ADDR-1:0]   rd;
        logic [`MIPS_NB_REG_ADDR-1:0]   shamt;
        logic [5:0]                     funct;
    } r_fields_t;

    // I-type layout
    typedef struct packed {
        logic [5:0]                     opcode;
        logic [`MIPS_NB_REG_ADDR-1:0]   rs;
        logic [`MIPS_NB_REG_ADDR-1:0]   rt;
        logic [15:0]                    imm;
    } i_fields_t;

    // Same word seen through both layouts
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5
    } alu_op_t;

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // Funct codes for R-type
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_SUB   = 6'h22;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

endpackage

// File: include/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath and instruction word width
`define MIPS_NB_DATA        32

// Register index width for 32 architectural registers
`define MIPS_NB_REG_ADDR    5

// Data memory size in words
`define MIPS_DMEM_DEPTH     64

// Word index into the data memory
`define MIPS_NB_DMEM_ADDR   6

`endif
